//--- core_input.txt
# P <instruction word> : program loaded from 0x80000000 upward
# S <address> <data>   : expected data-bus stores in order
P 10000093
P ff900113
P 00500193
P 00310233
P 403102b3
P 00312333
P 003133b3
P 00314433
P 003164b3
P 00317533
P 403155b3
P 00315633
P 003116b3
P 0040a023
P 0050a223
P 0060a423
P 0070a623
P 0080a823
P 0090aa23
P 00a0ac23
P 00b0ae23
P 02c0a023
P 02d0a223
P ffa12713
P 00513793
P 40115813
P 0f01c893
P 12345937
P 02e0a423
P 02f0a623
P 0300a823
P 0310aa23
P 0320ac23
P 00100993
P 00198993
P 00198993
P 0330ae23
P 00300a13
P 00000013
P 014a0ab3
P 00400b13
P 00000013
P 00000013
P 016b0bb3
P 0550a023
P 0570a223
P 0000ac03
P 003c0cb3
P 0590a423
P 00318463
P 0430a823
P 00319463
P 0430a623
P 00800d6f
P 0430a823
P 05a0aa23
P 05500013
P 0400ac23
P 3e302e23
P 0000006f
S 00000100 fffffffe
S 00000104 fffffff4
S 00000108 00000001
S 0000010c 00000000
S 00000110 fffffffc
S 00000114 fffffffd
S 00000118 00000001
S 0000011c ffffffff
S 00000120 07ffffff
S 00000124 ffffff20
S 00000128 00000001
S 0000012c 00000000
S 00000130 fffffffc
S 00000134 000000f5
S 00000138 12345000
S 0000013c 00000003
S 00000140 00000006
S 00000144 00000008
S 00000148 00000003
S 0000014c 00000005
S 00000154 800000d8
S 00000158 00000000
S 000003fc 00000005

//--- build.f
rv_pkg.sv
rv_regfile.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_memory.sv
rv_hazard_ctrl.sv
rv_core.sv
tb_rv_checker.sv
tb_rv_core.sv

//--- tb_rv_core.sv
// Testbench top that runs the program from core_input.txt on the core with random bus waits
module tb_rv_core
  import rv_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam xlen_t MARKER_ADDR = 32'h0000_03FC; // Last store of the program
  localparam int    RUN_LIMIT   = 5000;          // Cycles allowed to reach the marker
  localparam int    DRAIN       = 20;            // Cycles watched for late stores
  localparam int    WAIT_POOL   = 512;           // Wait draws kept per bus

  logic       clk_i;
  logic       rst_i;
  xlen_t      iwbm_addr_o;
  logic       iwbm_cyc_o;
  logic       iwbm_stb_o;
  xlen_t      iwbm_dat_i;
  logic       iwbm_ack_i;
  xlen_t      dwbm_addr_o;
  xlen_t      dwbm_dat_o;
  logic [3:0] dwbm_sel_o;
  logic       dwbm_cyc_o;
  logic       dwbm_stb_o;
  logic       dwbm_we_o;
  xlen_t      dwbm_dat_i;
  logic       dwbm_ack_i;

  xlen_t imem [0:255];
  xlen_t dmem [0:255];
  int    i_waits [0:WAIT_POOL-1];
  int    d_waits [0:WAIT_POOL-1];
  int    i_draw;
  int    d_draw;
  int    prog_len;
  int    i_wait;
  int    d_wait;
  int    mismatches;
  int    missing;
  int    extra;
  logic  timed_out;
  logic  file_bad;

  rv_core u_rv_core (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .iwbm_addr_o (iwbm_addr_o),
    .iwbm_cyc_o  (iwbm_cyc_o),
    .iwbm_stb_o  (iwbm_stb_o),
    .iwbm_dat_i  (iwbm_dat_i),
    .iwbm_ack_i  (iwbm_ack_i),
    .dwbm_addr_o (dwbm_addr_o),
    .dwbm_dat_o  (dwbm_dat_o),
    .dwbm_sel_o  (dwbm_sel_o),
    .dwbm_cyc_o  (dwbm_cyc_o),
    .dwbm_stb_o  (dwbm_stb_o),
    .dwbm_we_o   (dwbm_we_o),
    .dwbm_dat_i  (dwbm_dat_i),
    .dwbm_ack_i  (dwbm_ack_i)
  );

  tb_rv_checker u_checker (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .dwbm_addr_i (dwbm_addr_o),
    .dwbm_dat_i  (dwbm_dat_o),
    .dwbm_sel_i  (dwbm_sel_o),
    .dwbm_cyc_i  (dwbm_cyc_o),
    .dwbm_stb_i  (dwbm_stb_o),
    .dwbm_we_i   (dwbm_we_o),
    .dwbm_ack_i  (dwbm_ack_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Reads P lines into program memory and S lines into the checker queue
  task automatic read_stimulus();
    int    fd;
    int    n;
    string line;
    xlen_t a;
    xlen_t d;
    fd = $fopen("core_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open core_input.txt, no program to run");
      file_bad = 1'b1;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 0 && line[0] == "P") begin
        n = $sscanf(line, "P %h", d);
        imem[prog_len] = d;
        prog_len++;
      end else if (n > 0 && line.len() > 0 && line[0] == "S") begin
        n = $sscanf(line, "S %h %h", a, d);
        u_checker.add_expected(a, d);
      end
    end
    $fclose(fd);
  endtask

  // Instruction bus slave giving a one-cycle ack after 0 to 3 wait cycles
  always @(negedge clk_i) begin
    if (rst_i) begin
      iwbm_ack_i <= 1'b0;
      i_wait = -1;
    end else if (iwbm_ack_i) begin
      iwbm_ack_i <= 1'b0;
      i_wait = -1;
    end else if (iwbm_cyc_o && iwbm_stb_o) begin
      if (i_wait < 0) begin
        i_wait = i_waits[i_draw % WAIT_POOL];
        i_draw++;
      end
      if (i_wait == 0) begin
        iwbm_ack_i <= 1'b1;
        if ((iwbm_addr_o - RESET_ADDR) < 32'(prog_len * 4)) begin
          iwbm_dat_i <= imem[(iwbm_addr_o - RESET_ADDR) >> 2];
        end else begin
          iwbm_dat_i <= 32'h0000_0013; // nop past the program
        end
      end else begin
        i_wait = i_wait - 1;
      end
    end
  end

  // Data bus slave over a 1 KiB word memory
  always @(negedge clk_i) begin
    if (rst_i) begin
      dwbm_ack_i <= 1'b0;
      d_wait = -1;
    end else if (dwbm_ack_i) begin
      dwbm_ack_i <= 1'b0;
      d_wait = -1;
    end else if (dwbm_cyc_o && dwbm_stb_o) begin
      if (d_wait < 0) begin
        d_wait = d_waits[d_draw % WAIT_POOL];
        d_draw++;
      end
      if (d_wait == 0) begin
        dwbm_ack_i <= 1'b1;
        if (dwbm_we_o) begin
          dmem[dwbm_addr_o[9:2]] <= dwbm_dat_o;
        end else begin
          dwbm_dat_i <= dmem[dwbm_addr_o[9:2]];
        end
      end else begin
        d_wait = d_wait - 1;
      end
    end
  end

  initial begin
    int seed;
    logic marker_seen;
    rst_i      = 1'b1;
    iwbm_dat_i = '0;
    iwbm_ack_i = 1'b0;
    dwbm_dat_i = '0;
    dwbm_ack_i = 1'b0;
    prog_len   = 0;
    i_draw     = 0;
    d_draw     = 0;
    timed_out  = 1'b0;
    file_bad   = 1'b0;
    marker_seen = 1'b0;
    seed = 32'ha70e8bbd;
    void'($urandom(seed));
    // Wait cycles for both buses drawn up front
    for (int i = 0; i < WAIT_POOL; i++) begin
      i_waits[i] = $urandom % 4;
      d_waits[i] = $urandom % 4;
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i] = 32'h5a5a_0000 ^ (i << 2); // Word address folded into the pattern
    end
    read_stimulus();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    for (int c = 0; c < RUN_LIMIT && !marker_seen && !file_bad; c++) begin
      @(posedge clk_i);
      if (dwbm_cyc_o && dwbm_stb_o && dwbm_we_o && dwbm_ack_i &&
          dwbm_addr_o == MARKER_ADDR) begin
        marker_seen = 1'b1;
      end
    end
    if (!marker_seen && !file_bad) begin
      $display("Timeout: the program never stored to the marker address");
      timed_out = 1'b1;
    end
    repeat (DRAIN) @(posedge clk_i);
    mismatches = u_checker.mismatch_cnt;
    extra      = u_checker.extra_cnt;
    missing    = u_checker.exp_addr_q.size();
    $display("Store checks: %0d mismatched, %0d missing, %0d extra", mismatches, missing, extra);
    if (mismatches == 0 && missing == 0 && extra == 0 && !timed_out && !file_bad) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- tb_rv_checker.sv
// Store monitor that compares each acknowledged data-bus write with the expected sequence
module tb_rv_checker
  import rv_pkg::*;
(
  input logic       clk_i,
  input logic       rst_i,
  input xlen_t      dwbm_addr_i,
  input xlen_t      dwbm_dat_i,
  input logic [3:0] dwbm_sel_i,
  input logic       dwbm_cyc_i,
  input logic       dwbm_stb_i,
  input logic       dwbm_we_i,
  input logic       dwbm_ack_i
);
  timeunit 1ns;
  timeprecision 1ps;

  xlen_t exp_addr_q[$];
  xlen_t exp_data_q[$];
  int    mismatch_cnt = 0;
  int    extra_cnt    = 0;

  task automatic add_expected(input xlen_t addr, input xlen_t data);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(data);
  endtask

  // Pre-edge values of the access that completes on this edge
  always @(posedge clk_i) begin
    xlen_t ea;
    xlen_t ed;
    if (!rst_i && dwbm_cyc_i && dwbm_stb_i && dwbm_ack_i) begin
      if (dwbm_sel_i !== 4'hF) begin
        $display("** Error: dwbm_sel_o expected %h, got %h", 4'hF, dwbm_sel_i);
        mismatch_cnt++;
      end
      if (dwbm_we_i) begin
        if (exp_addr_q.size() == 0) begin
          $display("Unexpected extra store of %h to address %h", dwbm_dat_i, dwbm_addr_i);
          extra_cnt++;
        end else begin
          ea = exp_addr_q.pop_front();
          ed = exp_data_q.pop_front();
          if (dwbm_addr_i !== ea) begin
            $display("** Error: dwbm_addr_o expected %h, got %h", ea, dwbm_addr_i);
            mismatch_cnt++;
          end
          if (dwbm_dat_i !== ed) begin
            $display("** Error: dwbm_dat_o expected %h, got %h (address %h)",
                     ed, dwbm_dat_i, ea);
            mismatch_cnt++;
          end
        end
      end
    end
  end

  final begin
    if (exp_addr_q.size() != 0) begin
      $display("%0d expected stores never happened", exp_addr_q.size());
    end
  end

endmodule

//--- rv_core.sv
// Top level of the five-stage RV32I core with Wishbone instruction and data masters
module rv_core
  import rv_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  // Instruction bus
  output xlen_t      iwbm_addr_o,
  output logic       iwbm_cyc_o,
  output logic       iwbm_stb_o,
  input  xlen_t      iwbm_dat_i,
  input  logic       iwbm_ack_i,
  // Data bus
  output xlen_t      dwbm_addr_o,
  output xlen_t      dwbm_dat_o,
  output logic [3:0] dwbm_sel_o,
  output logic       dwbm_cyc_o,
  output logic       dwbm_stb_o,
  output logic       dwbm_we_o,
  input  xlen_t      dwbm_dat_i,
  input  logic       dwbm_ack_i
);

  xlen_t     if_instr;
  xlen_t     if_pc;
  logic      if_valid;
  logic      fetch_wait;
  logic      mem_wait;
  logic      stall;
  logic      freeze;
  logic      flush_if;
  fwd_sel_e  fwd_a;
  fwd_sel_e  fwd_b;
  xlen_t     ex_fwd;
  xlen_t     mem_fwd;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  mem_wb_t   mem_wb;
  reg_addr_t rs1;
  reg_addr_t rs2;
  logic      uses_rs1;
  logic      uses_rs2;
  logic      branch_taken;
  xlen_t     branch_target;

  rv_fetch u_fetch (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .stall_i         (stall),
    .freeze_i        (freeze),
    .flush_i         (flush_if),
    .branch_target_i (branch_target),
    .instr_o         (if_instr),
    .pc_o            (if_pc),
    .valid_o         (if_valid),
    .fetch_wait_o    (fetch_wait),
    .iwbm_addr_o     (iwbm_addr_o),
    .iwbm_cyc_o      (iwbm_cyc_o),
    .iwbm_stb_o      (iwbm_stb_o),
    .iwbm_dat_i      (iwbm_dat_i),
    .iwbm_ack_i      (iwbm_ack_i)
  );

  rv_decode u_decode (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .instr_i         (if_instr),
    .pc_i            (if_pc),
    .valid_i         (if_valid),
    .stall_i         (stall),
    .freeze_i        (freeze),
    .fwd_a_i         (fwd_a),
    .fwd_b_i         (fwd_b),
    .ex_fwd_i        (ex_fwd),
    .mem_fwd_i       (mem_fwd),
    .mem_wb_i        (mem_wb),
    .id_ex_o         (id_ex),
    .rs1_o           (rs1),
    .rs2_o           (rs2),
    .uses_rs1_o      (uses_rs1),
    .uses_rs2_o      (uses_rs2),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target)
  );

  rv_execute u_execute (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .freeze_i (freeze),
    .id_ex_i  (id_ex),
    .ex_mem_o (ex_mem),
    .ex_fwd_o (ex_fwd)
  );

  rv_memory u_memory (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .freeze_i    (freeze),
    .ex_mem_i    (ex_mem),
    .mem_wb_o    (mem_wb),
    .mem_fwd_o   (mem_fwd),
    .mem_wait_o  (mem_wait),
    .dwbm_addr_o (dwbm_addr_o),
    .dwbm_dat_o  (dwbm_dat_o),
    .dwbm_sel_o  (dwbm_sel_o),
    .dwbm_cyc_o  (dwbm_cyc_o),
    .dwbm_stb_o  (dwbm_stb_o),
    .dwbm_we_o   (dwbm_we_o),
    .dwbm_dat_i  (dwbm_dat_i),
    .dwbm_ack_i  (dwbm_ack_i)
  );

  rv_hazard_ctrl u_hazard_ctrl (
    .rs1_i          (rs1),
    .rs2_i          (rs2),
    .uses_rs1_i     (uses_rs1),
    .uses_rs2_i     (uses_rs2),
    .id_ex_i        (id_ex),
    .ex_mem_i       (ex_mem),
    .mem_wb_i       (mem_wb),
    .branch_taken_i (branch_taken),
    .fetch_wait_i   (fetch_wait),
    .mem_wait_i     (mem_wait),
    .fwd_a_o        (fwd_a),
    .fwd_b_o        (fwd_b),
    .stall_o        (stall),
    .freeze_o       (freeze),
    .flush_if_o     (flush_if)
  );

endmodule

//--- rv_hazard_ctrl.sv
// Hazard controller for operand forwarding, load-use stalls, bus-wait freezes and IF/ID flushes
module rv_hazard_ctrl
  import rv_pkg::*;
(
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  input  logic      uses_rs1_i,
  input  logic      uses_rs2_i,
  input  id_ex_t    id_ex_i,
  input  ex_mem_t   ex_mem_i,
  input  mem_wb_t   mem_wb_i,
  input  logic      branch_taken_i,
  input  logic      fetch_wait_i,
  input  logic      mem_wait_i,
  output fwd_sel_e  fwd_a_o,
  output fwd_sel_e  fwd_b_o,
  output logic      stall_o,
  output logic      freeze_o,
  output logic      flush_if_o
);

  logic load_hit_a;
  logic load_hit_b;

  // Youngest producer wins, x0 never forwards
  function automatic fwd_sel_e pick_src(reg_addr_t rs, id_ex_t ex, ex_mem_t mem, mem_wb_t wb);
    if (rs == '0) begin
      return FWD_RF;
    end
    if (ex.reg_write && ex.rd == rs) begin
      return FWD_EX;
    end
    if (mem.reg_write && mem.rd == rs) begin
      return FWD_MEM;
    end
    if (wb.reg_write && wb.rd == rs) begin
      return FWD_WB;
    end
    return FWD_RF;
  endfunction

  assign fwd_a_o = pick_src(rs1_i, id_ex_i, ex_mem_i, mem_wb_i);
  assign fwd_b_o = pick_src(rs2_i, id_ex_i, ex_mem_i, mem_wb_i);

  // Load data is not there until MEM
  assign load_hit_a = uses_rs1_i && rs1_i != '0 && rs1_i == id_ex_i.rd;
  assign load_hit_b = uses_rs2_i && rs2_i != '0 && rs2_i == id_ex_i.rd;
  assign stall_o    = id_ex_i.mem_read & (load_hit_a | load_hit_b);

  assign freeze_o   = fetch_wait_i | mem_wait_i;
  assign flush_if_o = branch_taken_i & ~stall_o; // Compare result not final while stalled

endmodule

//--- rv_memory.sv
// Memory stage driving the data bus master, picking load data and loading the MEM/WB register
module rv_memory
  import rv_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       freeze_i,
  input  ex_mem_t    ex_mem_i,
  output mem_wb_t    mem_wb_o,
  output xlen_t      mem_fwd_o,  // Stage result for decode forwarding
  output logic       mem_wait_o,
  output xlen_t      dwbm_addr_o,
  output xlen_t      dwbm_dat_o,
  output logic [3:0] dwbm_sel_o,
  output logic       dwbm_cyc_o,
  output logic       dwbm_stb_o,
  output logic       dwbm_we_o,
  input  xlen_t      dwbm_dat_i,
  input  logic       dwbm_ack_i
);

  logic  access;
  logic  done_q;     // Access acked, pipe still frozen by the fetch side
  xlen_t load_q;
  xlen_t load_data;
  xlen_t result;

  assign access = ex_mem_i.mem_read | ex_mem_i.mem_write;

  assign dwbm_addr_o = ex_mem_i.result;
  assign dwbm_dat_o  = ex_mem_i.store_data;
  assign dwbm_sel_o  = 4'hF;                // Word accesses only
  assign dwbm_cyc_o  = access & ~done_q;
  assign dwbm_stb_o  = access & ~done_q;
  assign dwbm_we_o   = ex_mem_i.mem_write & ~done_q;
  assign mem_wait_o  = dwbm_cyc_o & ~dwbm_ack_i;

  assign load_data = done_q ? load_q : dwbm_dat_i;
  assign result    = ex_mem_i.mem_read ? load_data : ex_mem_i.result;
  assign mem_fwd_o = result;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      done_q <= 1'b0;
    end else if (!freeze_i) begin
      done_q <= 1'b0;
    end else if (dwbm_cyc_o && dwbm_ack_i) begin
      done_q <= 1'b1;
      load_q <= dwbm_dat_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mem_wb_o.reg_write <= 1'b0;
    end else if (!freeze_i) begin
      mem_wb_o.result    <= result;
      mem_wb_o.rd        <= ex_mem_i.rd;
      mem_wb_o.reg_write <= ex_mem_i.reg_write;
    end
  end

endmodule

//--- rv_execute.sv
// Execute stage with the ALU and the EX/MEM register, also feeding its result back to decode
module rv_execute
  import rv_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    freeze_i,
  input  id_ex_t  id_ex_i,
  output ex_mem_t ex_mem_o,
  output xlen_t   ex_fwd_o
);

  xlen_t      alu_a;
  xlen_t      alu_b;
  logic [4:0] shamt;
  xlen_t      alu_res;

  assign alu_a = id_ex_i.op_a;
  assign alu_b = id_ex_i.link ? id_ex_i.op_a : id_ex_i.op_b; // Link address rides pass-B
  assign shamt = alu_b[4:0];

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD:    alu_res = alu_a + alu_b;
      ALU_SUB:    alu_res = alu_a - alu_b;
      ALU_AND:    alu_res = alu_a & alu_b;
      ALU_OR:     alu_res = alu_a | alu_b;
      ALU_XOR:    alu_res = alu_a ^ alu_b;
      ALU_SLT:    alu_res = {31'b0, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU:   alu_res = {31'b0, alu_a < alu_b};
      ALU_SLL:    alu_res = alu_a << shamt;
      ALU_SRL:    alu_res = alu_a >> shamt;
      ALU_SRA:    alu_res = xlen_t'($signed(alu_a) >>> shamt);
      ALU_PASS_B: alu_res = alu_b;
      default:    alu_res = '0;
    endcase
  end

  assign ex_fwd_o = alu_res;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ex_mem_o.mem_read  <= 1'b0;
      ex_mem_o.mem_write <= 1'b0;
      ex_mem_o.reg_write <= 1'b0;
    end else if (!freeze_i) begin
      ex_mem_o.result     <= alu_res;
      ex_mem_o.store_data <= id_ex_i.store_data;
      ex_mem_o.rd         <= id_ex_i.rd;
      ex_mem_o.mem_read   <= id_ex_i.mem_read;
      ex_mem_o.mem_write  <= id_ex_i.mem_write;
      ex_mem_o.reg_write  <= id_ex_i.reg_write;
    end
  end

endmodule

//--- rv_decode.sv
// Decode stage with register read, operand forwarding, branch resolution and the ID/EX register
module rv_decode
  import rv_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  xlen_t     instr_i,
  input  xlen_t     pc_i,
  input  logic      valid_i,
  input  logic      stall_i,
  input  logic      freeze_i,
  input  fwd_sel_e  fwd_a_i,
  input  fwd_sel_e  fwd_b_i,
  input  xlen_t     ex_fwd_i,
  input  xlen_t     mem_fwd_i,
  input  mem_wb_t   mem_wb_i,
  output id_ex_t    id_ex_o,
  output reg_addr_t rs1_o,
  output reg_addr_t rs2_o,
  output logic      uses_rs1_o,
  output logic      uses_rs2_o,
  output logic      branch_taken_o,
  output xlen_t     branch_target_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  xlen_t      rf_a;
  xlen_t      rf_b;
  xlen_t      src_a;
  xlen_t      src_b;
  logic       is_jal;
  logic       is_branch;
  logic       operands_eq;
  id_ex_t     id_ex_d;

  function automatic xlen_t fwd_mux(fwd_sel_e sel, xlen_t rf, xlen_t ex, xlen_t mem, xlen_t wb);
    case (sel)
      FWD_EX:  return ex;
      FWD_MEM: return mem;
      FWD_WB:  return wb;
      default: return rf;
    endcase
  endfunction

  // Shared by OP and OP-IMM, bit 30 only selects sub for the register form
  function automatic alu_op_e alu_decode(logic [2:0] f3, logic alt, logic reg_form);
    case (f3)
      3'b000:  return (alt && reg_form) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21],
                  1'b0};

  rv_regfile u_regfile (
    .clk_i    (clk_i),
    .rs1_i    (rs1_o),
    .rs2_i    (rs2_o),
    .rd_i     (mem_wb_i.rd),
    .wdata_i  (mem_wb_i.result),
    .we_i     (mem_wb_i.reg_write),
    .rdata1_o (rf_a),
    .rdata2_o (rf_b)
  );

  assign src_a = fwd_mux(fwd_a_i, rf_a, ex_fwd_i, mem_fwd_i, mem_wb_i.result);
  assign src_b = fwd_mux(fwd_b_i, rf_b, ex_fwd_i, mem_fwd_i, mem_wb_i.result);

  always_comb begin
    id_ex_d            = '0;
    id_ex_d.pc         = pc_i;
    id_ex_d.op_a       = src_a;
    id_ex_d.op_b       = src_b;
    id_ex_d.store_data = src_b;
    id_ex_d.rd         = instr_i[11:7];
    id_ex_d.alu_op     = ALU_ADD;
    uses_rs1_o         = 1'b0;
    uses_rs2_o         = 1'b0;
    is_jal             = 1'b0;
    is_branch          = 1'b0;
    case (opcode)
      OPC_OP: begin
        id_ex_d.alu_op    = alu_decode(funct3, instr_i[30], 1'b1);
        id_ex_d.reg_write = 1'b1;
        uses_rs1_o        = 1'b1;
        uses_rs2_o        = 1'b1;
      end
      OPC_OP_IMM: begin
        id_ex_d.op_b      = imm_i;
        id_ex_d.alu_op    = alu_decode(funct3, instr_i[30], 1'b0);
        id_ex_d.reg_write = 1'b1;
        uses_rs1_o        = 1'b1;
      end
      OPC_LOAD: begin
        id_ex_d.op_b      = imm_i;
        id_ex_d.mem_read  = 1'b1;
        id_ex_d.reg_write = 1'b1;
        uses_rs1_o        = 1'b1;
      end
      OPC_STORE: begin
        id_ex_d.op_b      = imm_s;
        id_ex_d.mem_write = 1'b1;
        uses_rs1_o        = 1'b1;
        uses_rs2_o        = 1'b1;
      end
      OPC_BRANCH: begin
        is_branch  = 1'b1;
        uses_rs1_o = 1'b1;
        uses_rs2_o = 1'b1;
      end
      OPC_JAL: begin
        id_ex_d.op_a      = pc_i + 32'd4; // Return address
        id_ex_d.alu_op    = ALU_PASS_B;
        id_ex_d.link      = 1'b1;
        id_ex_d.reg_write = 1'b1;
        is_jal            = 1'b1;
      end
      OPC_LUI: begin
        id_ex_d.op_b      = imm_u;
        id_ex_d.alu_op    = ALU_PASS_B;
        id_ex_d.reg_write = 1'b1;
      end
      default: ;
    endcase
    // A stall sends a bubble down instead of this instruction
    if (!valid_i || stall_i) begin
      id_ex_d.mem_read  = 1'b0;
      id_ex_d.mem_write = 1'b0;
      id_ex_d.reg_write = 1'b0;
      id_ex_d.link      = 1'b0;
    end
    if (!valid_i) begin
      uses_rs1_o = 1'b0;
      uses_rs2_o = 1'b0;
      is_jal     = 1'b0;
      is_branch  = 1'b0;
    end
  end

  assign operands_eq     = (src_a == src_b);
  assign branch_taken_o  = is_jal | (is_branch && ((funct3 == F3_BEQ && operands_eq) ||
                                                   (funct3 == F3_BNE && !operands_eq)));
  assign branch_target_o = pc_i + (is_jal ? imm_j : imm_b);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      id_ex_o.mem_read  <= 1'b0;
      id_ex_o.mem_write <= 1'b0;
      id_ex_o.reg_write <= 1'b0;
      id_ex_o.link      <= 1'b0;
    end else if (!freeze_i) begin
      id_ex_o <= id_ex_d;
    end
  end

endmodule

//--- rv_fetch.sv
// Fetch stage keeping the PC, running instruction bus requests and loading the IF/ID register
module rv_fetch
  import rv_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  stall_i,
  input  logic  freeze_i,
  input  logic  flush_i,
  input  xlen_t branch_target_i,
  output xlen_t instr_o,
  output xlen_t pc_o,
  output logic  valid_o,
  output logic  fetch_wait_o,
  output xlen_t iwbm_addr_o,
  output logic  iwbm_cyc_o,
  output logic  iwbm_stb_o,
  input  xlen_t iwbm_dat_i,
  input  logic  iwbm_ack_i
);

  xlen_t pc_q;          // Address of the fetch in progress
  logic  req_q;
  logic  hold_valid_q;  // Acked word parked while the pipe could not take it
  xlen_t hold_q;
  logic  word_rdy;
  xlen_t word;
  logic  redirect;
  logic  advance;

  assign word_rdy     = hold_valid_q | (req_q & iwbm_ack_i);
  assign word         = hold_valid_q ? hold_q : iwbm_dat_i;
  assign redirect     = flush_i & ~freeze_i;
  assign advance      = ~stall_i & ~freeze_i;
  assign fetch_wait_o = req_q & ~iwbm_ack_i;

  assign iwbm_addr_o = pc_q;
  assign iwbm_cyc_o  = req_q;
  assign iwbm_stb_o  = req_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q         <= RESET_ADDR;
      req_q        <= 1'b0;
      hold_valid_q <= 1'b0;
      valid_o      <= 1'b0;
    end else if (redirect) begin
      // Word at the old PC is the one squashed slot
      pc_q         <= branch_target_i;
      req_q        <= 1'b1;
      hold_valid_q <= 1'b0;
      valid_o      <= 1'b0;
    end else if (advance) begin
      instr_o      <= word;
      pc_o         <= pc_q;
      valid_o      <= word_rdy;
      req_q        <= 1'b1;
      hold_valid_q <= 1'b0;
      if (word_rdy) begin
        pc_q <= pc_q + 32'd4;
      end
    end else if (req_q && iwbm_ack_i) begin
      hold_q       <= iwbm_dat_i; // Stalled, keep the word and close the cycle
      hold_valid_q <= 1'b1;
      req_q        <= 1'b0;
    end
  end

endmodule

//--- rv_regfile.sv
// General register file with two combinational read ports and one write port, x0 reads zero
module rv_regfile
  import rv_pkg::*;
(
  input  logic      clk_i,
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  input  reg_addr_t rd_i,
  input  xlen_t     wdata_i,
  input  logic      we_i,
  output xlen_t     rdata1_o,
  output xlen_t     rdata2_o
);

  xlen_t regs [1:31];

  always_ff @(posedge clk_i) begin
    if (we_i && rd_i != '0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

//--- rv_pkg.sv
// Types, opcodes and stage bundles shared by the core modules through a wildcard import
package rv_pkg;

  typedef logic [31:0] xlen_t;     // Data and address word
  typedef logic [4:0]  reg_addr_t; // Register index

  localparam xlen_t RESET_ADDR = 32'h8000_0000;

  // Major opcodes of the supported subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_e;

  // Where a decode operand comes from
  typedef enum logic [1:0] {
    FWD_RF,
    FWD_EX,
    FWD_MEM,
    FWD_WB
  } fwd_sel_e;

  typedef struct packed {
    xlen_t     pc;
    xlen_t     op_a;
    xlen_t     op_b;
    xlen_t     store_data;
    reg_addr_t rd;
    alu_op_e   alu_op;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    logic      link;       // jal, op_a holds the return address
  } id_ex_t;

  typedef struct packed {
    xlen_t     result;     // ALU result, also the data address
    xlen_t     store_data;
    reg_addr_t rd;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
  } ex_mem_t;

  typedef struct packed {
    xlen_t     result;
    reg_addr_t rd;
    logic      reg_write;
  } mem_wb_t;

endpackage
